// File: uop_params.svh
`ifndef UOP_PARAMS_SVH
`define UOP_PARAMS_SVH

// Widths.
`define WORD_W          32
`define UOP_W           35
`define REG_IDX_W       5
`define REG_LIST_W      16

// First fetch address.
`define RESET_PC        32'h0000_0000

// Register fields and their extension bits.
`define BASE            19:16
`define BASE_EXT        33
`define SRCDEST         15:12
`define SRCDEST_EXT     32
`define DP_RD           15:12
`define DP_RD_EXT       32
`define DP_RS           3:0
`define DP_RS_EXT       34

// Extended register indices.
`define ARCH_PC         5'd15
`define DUMMY_REG0      5'd16
`define DUMMY_REG1      5'd17
`define USR_R8_BASE     5'd18

// Data processing opcode.
`define OPC_MOV         4'b1101

`endif

// File: uop_pkg.sv
`include "uop_params.svh"

package uop_pkg;

        // Instruction word, also the bus data and address width.
        typedef logic [`WORD_W-1:0] word_t;

        // Micro-op.
        // Bits 31:0 hold an ARM word, 32 to 34 extend Rd, Rn and Rm.
        typedef logic [`UOP_W-1:0] uop_t;

        // Extended register index.
        // 0 to 15 architectural, 16 and 17 dummies, 18 to 24 user bank r8 to r14.
        typedef logic [`REG_IDX_W-1:0] reg_idx_t;

        // Register list of a block transfer.
        typedef logic [`REG_LIST_W-1:0] reg_list_t;

        // Sequencer states.
        typedef enum logic [2:0]
        {
                IDLE,
                MEMOP,
                WRITE_PC,
                SWAP1,
                SWAP2
        } seq_state_t;

endpackage

// File: insn_fetch.sv
`timescale 1ns/1ns
`include "uop_params.svh"

module insn_fetch
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Wishbone classic master.
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output uop_pkg::word_t          o_wb_adr,
        output logic                    o_wb_we,
        input  uop_pkg::word_t          i_wb_dat,
        input  logic                    i_wb_ack,

        input  logic                    i_irq,
        input  logic                    i_fiq,

        // One-entry instruction buffer.
        input  logic                    i_take,
        output uop_pkg::word_t          o_insn,
        output logic                    o_valid,
        output logic                    o_irq,
        output logic                    o_fiq
);

        logic                   wb_req;
        logic                   wb_done;
        uop_pkg::word_t         pc;

        assign wb_done  = wb_req && i_wb_ack;

        assign o_wb_cyc = wb_req;
        assign o_wb_stb = wb_req;
        assign o_wb_adr = pc;
        assign o_wb_we  = 1'b0;

        // A read starts only with the buffer free, so a completed read never overwrites.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        wb_req <= 1'b0;
                        pc     <= `RESET_PC;
                end
                else if (wb_done)
                begin
                        wb_req <= 1'b0;
                        pc     <= pc + 32'd4;
                end
                else if (!wb_req && (!o_valid || i_take))
                begin
                        wb_req <= 1'b1;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_valid <= 1'b0;
                else if (wb_done)
                        o_valid <= 1'b1;
                else if (i_take)
                        o_valid <= 1'b0;
        end

        // Word and interrupt flags captured together.
        always_ff @(posedge i_clk)
        begin
                if (wb_done)
                begin
                        o_insn <= i_wb_dat;
                        o_irq  <= i_irq;
                        o_fiq  <= i_fiq;
                end
        end

endmodule

// File: block_xfer_sequencer.sv
`timescale 1ns/1ns
`include "uop_params.svh"

module block_xfer_sequencer
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_flush,

        // From the fetch buffer.
        input  uop_pkg::word_t          i_insn,
        input  logic                    i_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        output logic                    o_take,

        // To the issue register.
        input  logic                    i_ready,
        output uop_pkg::uop_t           o_uop,
        output logic                    o_uop_valid,
        output logic                    o_irq,
        output logic                    o_fiq
);

        uop_pkg::seq_state_t    state_ff;
        uop_pkg::seq_state_t    state_nxt;
        uop_pkg::reg_list_t     list_ff;
        uop_pkg::reg_list_t     list_nxt;
        logic [3:0]             enc;
        logic                   last;
        logic [3:0]             cc;
        logic                   up;
        logic                   s_bit;
        logic                   load;
        logic                   is_multi;
        logic                   is_swp;

        // Next register of the list, by transfer direction.
        function automatic logic [3:0] pri_enc(input uop_pkg::reg_list_t list,
                                               input logic low_first);
                logic [3:0] sel;

                sel = 4'd0;
                if (low_first)
                begin
                        for (int i = 15; i >= 0; i--)
                                if (list[i])
                                        sel = 4'(i);
                end
                else
                begin
                        for (int i = 0; i <= 15; i++)
                                if (list[i])
                                        sel = 4'(i);
                end
                return sel;
        endfunction

        // MOV(S) rd, rm on extended indices.
        function automatic uop_pkg::uop_t mov_uop(input logic [3:0] cond, input logic s,
                                                  input uop_pkg::reg_idx_t rd,
                                                  input uop_pkg::reg_idx_t rm);
                uop_pkg::uop_t u;

                u = '0;
                u[31:0] = {cond, 2'b00, 1'b0, `OPC_MOV, s, 4'd0, 4'd0, 8'd0, 4'd0};
                {u[`DP_RD_EXT], u[`DP_RD]} = rd;
                {u[`DP_RS_EXT], u[`DP_RS]} = rm;
                return u;
        endfunction

        // LDR or STR rt, [Rn] for the swap.
        function automatic uop_pkg::uop_t swp_uop(input uop_pkg::word_t insn, input logic ld,
                                                  input uop_pkg::reg_idx_t rt);
                uop_pkg::uop_t u;

                u = '0;
                u[31:0] = {insn[31:28], 3'b010, 1'b1, 1'b1, insn[22], 1'b0, ld,
                           insn[`BASE], 4'd0, 12'd0};
                {u[`SRCDEST_EXT], u[`SRCDEST]} = rt;
                return u;
        endfunction

        // One list entry as a single transfer of immediate 4 off DUMMY_REG0.
        // An empty list gives the base restore or a no-op.
        function automatic uop_pkg::uop_t map_xfer(input uop_pkg::word_t insn,
                                                   input logic [3:0] idx,
                                                   input uop_pkg::reg_list_t list);
                uop_pkg::uop_t          u;
                uop_pkg::reg_idx_t      usr;
                logic                   ld;
                logic                   s;

                ld  = insn[20];
                s   = insn[22];
                usr = `USR_R8_BASE + {1'b0, idx - 4'd8};

                u = {3'b000, insn};
                u[27:25] = 3'b010;
                u[22] = 1'b0;
                u[11:0] = 12'd4;
                u[`SRCDEST] = idx;
                {u[`BASE_EXT], u[`BASE]} = `DUMMY_REG0;
                // Post-indexed writes back anyway.
                if (!insn[24])
                        u[21] = 1'b0;

                if (list == '0)
                begin
                        if (insn[21])
                                u = mov_uop(insn[31:28], 1'b0, {1'b0, insn[`BASE]}, `DUMMY_REG0);
                        else
                                u = '0;
                end
                else if (s && (!ld || !insn[`ARCH_PC]) && idx >= 4'd8 && idx <= 4'd14)
                begin
                        {u[`SRCDEST_EXT], u[`SRCDEST]} = usr;
                end
                else if (ld && idx == 4'd15)
                begin
                        {u[`SRCDEST_EXT], u[`SRCDEST]} = `DUMMY_REG1;
                end
                return u;
        endfunction

        assign cc       = i_insn[31:28];
        assign up       = i_insn[23];
        assign s_bit    = i_insn[22];
        assign load     = i_insn[20];
        assign is_multi = i_valid && (i_insn[27:25] == 3'b100);
        assign is_swp   = i_valid && (i_insn[27:23] == 5'b00010) && (i_insn[21:20] == 2'b00) &&
                          (i_insn[11:4] == 8'b0000_1001);
        assign enc      = pri_enc(list_ff, up);
        assign o_take   = last && i_ready && !i_flush;

        always_comb
        begin
                state_nxt   = state_ff;
                list_nxt    = list_ff;
                o_uop       = {3'b000, i_insn};
                o_uop_valid = 1'b1;
                o_irq       = 1'b0;
                o_fiq       = 1'b0;
                last        = 1'b0;

                case (state_ff)
                uop_pkg::IDLE:
                begin
                        // First micro-op carries the interrupt flags.
                        o_irq = i_irq && i_valid;
                        o_fiq = i_fiq && i_valid;
                        if (is_multi)
                        begin
                                o_uop     = mov_uop(cc, 1'b0, `DUMMY_REG0, {1'b0, i_insn[`BASE]});
                                list_nxt  = i_insn[15:0];
                                state_nxt = uop_pkg::MEMOP;
                        end
                        else if (is_swp)
                        begin
                                o_uop     = swp_uop(i_insn, 1'b1, `DUMMY_REG0);
                                state_nxt = uop_pkg::SWAP1;
                        end
                        else
                        begin
                                o_uop_valid = i_valid;
                                list_nxt    = '0;
                                last        = i_valid;
                        end
                end
                uop_pkg::SWAP1:
                begin
                        o_uop     = swp_uop(i_insn, 1'b0, {1'b0, i_insn[`DP_RS]});
                        state_nxt = uop_pkg::SWAP2;
                end
                uop_pkg::SWAP2:
                begin
                        o_uop     = mov_uop(cc, 1'b0, {1'b0, i_insn[`DP_RD]}, `DUMMY_REG0);
                        last      = 1'b1;
                        state_nxt = uop_pkg::IDLE;
                end
                uop_pkg::MEMOP:
                begin
                        o_uop    = map_xfer(i_insn, enc, list_ff);
                        list_nxt = list_ff & ~(16'd1 << enc);
                        if (list_ff == '0)
                        begin
                                if (load && i_insn[`ARCH_PC])
                                begin
                                        state_nxt = uop_pkg::WRITE_PC;
                                end
                                else
                                begin
                                        last      = 1'b1;
                                        state_nxt = uop_pkg::IDLE;
                                end
                        end
                end
                uop_pkg::WRITE_PC:
                begin
                        // MOVS returns with the saved status.
                        o_uop     = mov_uop(cc, s_bit, `ARCH_PC, `DUMMY_REG1);
                        last      = 1'b1;
                        state_nxt = uop_pkg::IDLE;
                end
                default:
                begin
                        state_nxt = uop_pkg::IDLE;
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        state_ff <= uop_pkg::IDLE;
                        list_ff  <= '0;
                end
                else if (i_ready)
                begin
                        state_ff <= state_nxt;
                        list_ff  <= list_nxt;
                end
        end

endmodule

// File: uop_issue_reg.sv
`timescale 1ns/1ns

module uop_issue_reg
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_flush,

        // From the sequencer.
        input  uop_pkg::uop_t           i_uop,
        input  logic                    i_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        output logic                    o_ready,

        // To the rest of the core.
        input  logic                    i_stall,
        output uop_pkg::uop_t           o_uop,
        output logic                    o_uop_valid,
        output logic                    o_irq,
        output logic                    o_fiq
);

        // Held only while full and stalled.
        assign o_ready = !(o_uop_valid && i_stall);

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_uop_valid <= 1'b0;
                        o_irq       <= 1'b0;
                        o_fiq       <= 1'b0;
                end
                else if (o_ready)
                begin
                        o_uop_valid <= i_valid;
                        o_irq       <= i_irq;
                        o_fiq       <= i_fiq;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (o_ready)
                        o_uop <= i_uop;
        end

endmodule

// File: uop_expander_top.sv
`timescale 1ns/1ns

module uop_expander_top
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_flush,
        input  logic                    i_stall,
        input  logic                    i_irq,
        input  logic                    i_fiq,

        // Wishbone classic instruction port.
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output uop_pkg::word_t          o_wb_adr,
        output logic                    o_wb_we,
        input  uop_pkg::word_t          i_wb_dat,
        input  logic                    i_wb_ack,

        // Micro-op stream.
        output uop_pkg::uop_t           o_uop,
        output logic                    o_uop_valid,
        output logic                    o_irq,
        output logic                    o_fiq
);

        uop_pkg::word_t         fetch_insn;
        logic                   fetch_valid;
        logic                   fetch_irq;
        logic                   fetch_fiq;
        logic                   seq_take;

        uop_pkg::uop_t          seq_uop;
        logic                   seq_uop_valid;
        logic                   seq_irq;
        logic                   seq_fiq;
        logic                   issue_ready;

        insn_fetch u_fetch
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .o_wb_cyc       (o_wb_cyc),
                .o_wb_stb       (o_wb_stb),
                .o_wb_adr       (o_wb_adr),
                .o_wb_we        (o_wb_we),
                .i_wb_dat       (i_wb_dat),
                .i_wb_ack       (i_wb_ack),
                .i_irq          (i_irq),
                .i_fiq          (i_fiq),
                .i_take         (seq_take),
                .o_insn         (fetch_insn),
                .o_valid        (fetch_valid),
                .o_irq          (fetch_irq),
                .o_fiq          (fetch_fiq)
        );

        block_xfer_sequencer u_seq
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_insn         (fetch_insn),
                .i_valid        (fetch_valid),
                .i_irq          (fetch_irq),
                .i_fiq          (fetch_fiq),
                .o_take         (seq_take),
                .i_ready        (issue_ready),
                .o_uop          (seq_uop),
                .o_uop_valid    (seq_uop_valid),
                .o_irq          (seq_irq),
                .o_fiq          (seq_fiq)
        );

        uop_issue_reg u_issue
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_uop          (seq_uop),
                .i_valid        (seq_uop_valid),
                .i_irq          (seq_irq),
                .i_fiq          (seq_fiq),
                .o_ready        (issue_ready),
                .i_stall        (i_stall),
                .o_uop          (o_uop),
                .o_uop_valid    (o_uop_valid),
                .o_irq          (o_irq),
                .o_fiq          (o_fiq)
        );

endmodule

// File: tb_uop_tasks.svh
`ifndef TB_UOP_TASKS_SVH
`define TB_UOP_TASKS_SVH

// MOV(S) rd, rm with extension bits 32 and 34.
function automatic uop_pkg::uop_t make_mov(input logic [3:0] cond, input logic s,
                                           input uop_pkg::reg_idx_t rd,
                                           input uop_pkg::reg_idx_t rm);
        return {rm[4], 1'b0, rd[4], cond, 7'b0001101, s, 4'h0, rd[3:0], 8'h00, rm[3:0]};
endfunction

// One list register as LDR or STR off DUMMY_REG0 with immediate 4.
function automatic uop_pkg::uop_t make_xfer(input uop_pkg::word_t insn, input int r);
        uop_pkg::reg_idx_t      rd;
        logic                   wb;

        rd = 5'(r);
        if (insn[22] && (!insn[20] || !insn[15]) && r >= 8 && r <= 14)
                rd = 5'(r + 10);
        else if (insn[20] && r == 15)
                rd = `DUMMY_REG1;
        wb = insn[24] & insn[21];
        return {2'b01, rd[4], insn[31:28], 3'b010, insn[24], insn[23], 1'b0, wb, insn[20],
                4'h0, rd[3:0], 12'h004};
endfunction

task automatic add_expected(input uop_pkg::uop_t u, input logic first);
        expq.push_back({irq_on && first, irq_on && first, u});
endtask

// Reference expansion of one instruction.
task automatic expand_insn(input uop_pkg::word_t insn);
        logic [3:0]             cc;
        uop_pkg::reg_idx_t      rn;
        int                     k;
        int                     r;

        cc = insn[31:28];
        rn = {1'b0, insn[19:16]};
        if (insn[27:25] == 3'b100)
        begin
                add_expected(make_mov(cc, 1'b0, `DUMMY_REG0, rn), 1'b1);
                for (k = 0; k < 16; k++)
                begin
                        r = insn[23] ? k : 15 - k;
                        if (insn[r])
                                add_expected(make_xfer(insn, r), 1'b0);
                end
                add_expected(insn[21] ? make_mov(cc, 1'b0, rn, `DUMMY_REG0) : '0, 1'b0);
                if (insn[20] && insn[15])
                        add_expected(make_mov(cc, insn[22], `ARCH_PC, `DUMMY_REG1), 1'b0);
        end
        else if (insn[27:23] == 5'b00010 && insn[21:20] == 2'b00 && insn[11:4] == 8'h09)
        begin
                add_expected({3'b001, cc, 5'b01011, insn[22], 2'b01, insn[19:16], 16'h0}, 1'b1);
                add_expected({3'b000, cc, 5'b01011, insn[22], 2'b00, insn[19:16], insn[3:0],
                              12'h0}, 1'b0);
                add_expected(make_mov(cc, 1'b0, {1'b0, insn[15:12]}, `DUMMY_REG0), 1'b0);
        end
        else
        begin
                add_expected({3'b000, insn}, 1'b1);
        end
endtask

task automatic load_insn(input uop_pkg::word_t insn);
        prog[n_insn] = insn;
        n_insn++;
        expand_insn(insn);
endtask

task automatic begin_test(input logic stall_on, input logic flags_on);
        @(posedge i_clk);
        #10;
        test_errors = errors;
        stall_rand  = stall_on;
        irq_on      = flags_on;
        i_irq       = flags_on;
        i_fiq       = flags_on;
        n_insn      = 0;
        expq.delete();
        // Filler is an ADD immediate that encodes its own word index.
        for (int i = 0; i < 256; i++)
                prog[i] = 32'hE280_0000 | i;
endtask

task automatic reset_dut();
        @(posedge i_clk);
        #10;
        i_reset = 1'b1;
        repeat (10) @(posedge i_clk);
        #10;
        if ({o_wb_cyc, o_wb_stb, o_uop_valid, o_irq, o_fiq} !== 5'b0)
                report_mismatch("{o_wb_cyc, o_wb_stb, o_uop_valid, o_irq, o_fiq} in reset",
                                {o_wb_cyc, o_wb_stb, o_uop_valid, o_irq, o_fiq}, 0);
        i_reset = 1'b0;
        got.delete();
endtask

task automatic wait_for_uops(input int n);
        int cycles;

        cycles = 0;
        while (got.size() < n && cycles < 3000)
        begin
                @(posedge i_clk);
                cycles++;
        end
        if (got.size() < n)
        begin
                $display("timeout: only %0d of %0d micro-ops arrived", got.size(), n);
                errors++;
        end
endtask

task automatic check_stream();
        logic [`UOP_W+1:0]      g;
        logic [`UOP_W+1:0]      e;
        int                     i;

        wait_for_uops(expq.size());
        for (i = 0; i < expq.size() && i < got.size(); i++)
        begin
                g = got[i];
                e = expq[i];
                if (g[`UOP_W-1:0] !== e[`UOP_W-1:0])
                        report_mismatch($sformatf("o_uop[%0d]", i), g[`UOP_W-1:0],
                                        e[`UOP_W-1:0]);
                if (g[`UOP_W] !== e[`UOP_W])
                        report_mismatch($sformatf("o_irq[%0d]", i), g[`UOP_W], e[`UOP_W]);
                if (g[`UOP_W+1] !== e[`UOP_W+1])
                        report_mismatch($sformatf("o_fiq[%0d]", i), g[`UOP_W+1], e[`UOP_W+1]);
        end
endtask

task automatic end_test(input string name);
        if (errors == test_errors)
        begin
                $display("%s: pass", name);
                tests_passed++;
        end
        else
        begin
                $display("%s: fail, %0d errors", name, errors - test_errors);
                tests_failed++;
        end
endtask

task automatic run_plain_test();
        begin_test(1'b0, 1'b0);
        load_insn(32'hE081_2003);
        load_insn(32'hE3A0_0005);
        load_insn(32'hE591_2004);
        load_insn(32'hE1A0_1002);
        reset_dut();
        check_stream();
        end_test("plain pass-through");
endtask

task automatic run_block_test();
        begin_test(1'b0, 1'b0);
        load_insn(32'hE8B1_0034);
        load_insn(32'hE92D_4030);
        load_insn(32'hE3A0_0005);
        load_insn(32'hE990_000A);
        load_insn(32'hE802_0081);
        reset_dut();
        check_stream();
        end_test("ldm and stm ordering");
endtask

task automatic run_swap_test();
        begin_test(1'b0, 1'b0);
        load_insn(32'hE103_1092);
        load_insn(32'hE143_5096);
        reset_dut();
        check_stream();
        end_test("swp and swpb");
endtask

task automatic run_user_bank_test();
        begin_test(1'b0, 1'b0);
        load_insn(32'hE8F0_8002);
        load_insn(32'hE94D_4300);
        load_insn(32'hE8D1_1100);
        reset_dut();
        check_stream();
        end_test("pc load and user bank");
endtask

task automatic run_stall_test();
        logic [`UOP_W+1:0]      calm[$];
        int                     i;

        begin_test(1'b0, 1'b0);
        load_insn(32'hE8B1_0034);
        load_insn(32'hE081_2003);
        load_insn(32'hE103_1092);
        load_insn(32'hE92D_4030);
        load_insn(32'hE8F0_8002);
        reset_dut();
        check_stream();
        calm = got;
        stall_rand = 1'b1;
        reset_dut();
        check_stream();
        for (i = 0; i < expq.size() && i < got.size() && i < calm.size(); i++)
                if (got[i] !== calm[i])
                        report_mismatch($sformatf("stalled o_uop[%0d]", i), got[i], calm[i]);
        stall_rand = 1'b0;
        end_test("random stall and bus waits");
endtask

task automatic run_irq_flush_test();
        begin_test(1'b0, 1'b1);
        load_insn(32'hE8B1_0034);
        load_insn(32'hE103_1092);
        load_insn(32'hE081_2003);
        reset_dut();
        check_stream();
        // Same program again with a flush inside the LDM.
        reset_dut();
        wait_for_uops(3);
        #10;
        i_flush = 1'b1;
        @(posedge i_clk);
        #10;
        i_flush = 1'b0;
        if (o_uop_valid !== 1'b0)
                report_mismatch("o_uop_valid after flush", o_uop_valid, 0);
        got.delete();
        check_stream();
        end_test("interrupt flags and flush");
endtask

`endif

// File: tb_uop_expander.sv
`timescale 1ns/1ns
`include "uop_params.svh"

module tb_uop_expander;

        logic                   i_clk;
        logic                   i_reset;
        logic                   i_flush;
        logic                   i_stall;
        logic                   i_irq;
        logic                   i_fiq;
        logic                   o_wb_cyc;
        logic                   o_wb_stb;
        uop_pkg::word_t         o_wb_adr;
        logic                   o_wb_we;
        uop_pkg::word_t         i_wb_dat;
        logic                   i_wb_ack;
        uop_pkg::uop_t          o_uop;
        logic                   o_uop_valid;
        logic                   o_irq;
        logic                   o_fiq;

        // Program memory and bus model state.
        uop_pkg::word_t         prog[0:255];
        uop_pkg::word_t         next_adr;
        int                     wait_left;
        logic [31:0]            lcg_state;
        logic                   stall_rand;
        logic                   irq_on;

        // Streams hold {fiq, irq, uop}.
        logic [`UOP_W+1:0]      expq[$];
        logic [`UOP_W+1:0]      got[$];
        logic                   held;
        logic [`UOP_W+1:0]      held_val;

        int                     errors;
        int                     test_errors;
        int                     tests_passed;
        int                     tests_failed;
        int                     n_insn;

        uop_expander_top i_dut
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_stall        (i_stall),
                .i_irq          (i_irq),
                .i_fiq          (i_fiq),
                .o_wb_cyc       (o_wb_cyc),
                .o_wb_stb       (o_wb_stb),
                .o_wb_adr       (o_wb_adr),
                .o_wb_we        (o_wb_we),
                .i_wb_dat       (i_wb_dat),
                .i_wb_ack       (i_wb_ack),
                .o_uop          (o_uop),
                .o_uop_valid    (o_uop_valid),
                .o_irq          (o_irq),
                .o_fiq          (o_fiq)
        );

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        task automatic report_mismatch(input string sig, input logic [63:0] got_v,
                                       input logic [63:0] exp_v);
                $display("error at %0t ns: %s is %h, expected %h", $time, sig, got_v, exp_v);
                errors++;
        endtask

        initial
        begin
                i_clk = 1'b0;
                forever
                        #50 i_clk = ~i_clk;
        end

        // Wishbone slave with random ack delay, plus the downstream stall.
        initial
        begin
                logic [31:0] r;

                i_wb_ack  = 1'b0;
                i_wb_dat  = '0;
                wait_left = -1;
                next_adr  = `RESET_PC;
                forever
                begin
                        @(posedge i_clk);
                        #10;
                        r = lcg_next();
                        i_stall = stall_rand && r[20];
                        if (i_reset)
                        begin
                                i_wb_ack  = 1'b0;
                                wait_left = -1;
                                next_adr  = `RESET_PC;
                        end
                        else if (i_wb_ack)
                        begin
                                i_wb_ack = 1'b0;
                        end
                        else if (o_wb_cyc && o_wb_stb)
                        begin
                                if (wait_left < 0)
                                        wait_left = r[25:24];
                                if (wait_left == 0)
                                begin
                                        if (o_wb_adr !== next_adr)
                                                report_mismatch("o_wb_adr", o_wb_adr, next_adr);
                                        if (o_wb_we !== 1'b0)
                                                report_mismatch("o_wb_we", o_wb_we, 0);
                                        i_wb_dat  = prog[o_wb_adr[9:2]];
                                        i_wb_ack  = 1'b1;
                                        next_adr  = next_adr + 32'd4;
                                        wait_left = -1;
                                end
                                else
                                begin
                                        wait_left--;
                                end
                        end
                end
        end

        // Downstream side, sampled mid-cycle.
        always @(negedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        held = 1'b0;
                end
                else
                begin
                        if (held && (o_uop_valid !== 1'b1 || {o_fiq, o_irq, o_uop} !== held_val))
                                report_mismatch("o_uop under stall", {o_fiq, o_irq, o_uop},
                                                held_val);
                        if (o_uop_valid && !i_stall)
                                got.push_back({o_fiq, o_irq, o_uop});
                        held     = o_uop_valid && i_stall;
                        held_val = {o_fiq, o_irq, o_uop};
                end
        end

        `include "tb_uop_tasks.svh"

        initial
        begin
                i_reset      = 1'b1;
                i_flush      = 1'b0;
                i_stall      = 1'b0;
                i_irq        = 1'b0;
                i_fiq        = 1'b0;
                lcg_state    = 32'h4422;
                stall_rand   = 1'b0;
                irq_on       = 1'b0;
                held         = 1'b0;
                errors       = 0;
                tests_passed = 0;
                tests_failed = 0;

                run_plain_test();
                run_block_test();
                run_swap_test();
                run_user_bank_test();
                run_stall_test();
                run_irq_flush_test();

                $display("tests: %0d passed, %0d failed, %0d errors",
                         tests_passed, tests_failed, errors);
                if (errors == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

// File: src.f
+incdir+.
uop_pkg.sv
insn_fetch.sv
block_xfer_sequencer.sv
uop_issue_reg.sv
uop_expander_top.sv
tb_uop_expander.sv

// File: Bender.yml
package:
  name: uop_expander

sources:
  - include_dirs:
      - .
    files:
      - uop_pkg.sv
      - insn_fetch.sv
      - block_xfer_sequencer.sv
      - uop_issue_reg.sv
      - uop_expander_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uop_expander.sv
